//--- src/hwpf_pkg.sv
/*
 * Shared definitions for the snooping stride prefetcher:
 * line-address type, training region size and walker state encoding,
 * plus the region compare used while training
 */

package hwpf_pkg;

  // Physical cache-line address carried by snoops and requests
  localparam int unsigned NLINE_WIDTH = 26;

  typedef logic [NLINE_WIDTH-1:0] hwpf_nline_t;

  // A second snoop trains an engine only inside this many lines of its base
  localparam int unsigned TRAIN_MASK_LINES = 16;
  localparam int unsigned TRAIN_REGION_LSB = $clog2(TRAIN_MASK_LINES);

  // Walker FSM states
  typedef enum logic [1:0] {
    HWPF_IDLE     = 2'd0,
    HWPF_TRAIN    = 2'd1,
    HWPF_PREFETCH = 2'd2
  } hwpf_state_t;

  // True when both lines fall in the same aligned training region
  function automatic logic hwpf_same_region(
    input hwpf_nline_t line_a,
    input hwpf_nline_t line_b
  );
    return line_a[NLINE_WIDTH-1:TRAIN_REGION_LSB] == line_b[NLINE_WIDTH-1:TRAIN_REGION_LSB];
  endfunction

endpackage

//--- src/hwpf_window_if.sv
/*
 * Prefetch window interface from a walker to its request generator:
 * base line, signed stride, log2 burst length, load pulse and enable
 */

`timescale 1ns/100ps

interface hwpf_window_if #(
  parameter int unsigned STRIDE_WIDTH   = 12,
  parameter int unsigned MAX_LOG2_BURST = 3
);
  import hwpf_pkg::*;

  localparam int unsigned LCOUNT_WIDTH = $clog2(MAX_LOG2_BURST + 1);

  // First line of the burst to issue
  hwpf_nline_t                    base;
  logic signed [STRIDE_WIDTH-1:0] stride;
  logic        [LCOUNT_WIDTH-1:0] lcount;
  // Single-cycle load strobe
  logic                           update;
  // High while the walker sits in Prefetch
  logic                           ena;

  modport walker (output base, stride, lcount, update, ena);
  modport gen    (input  base, stride, lcount, update, ena);

endinterface

//--- src/hwpf_snoop_dispatch.sv
/*
 * Snoop dispatcher: registers the incoming snoop line and selects
 * one engine by match class (prefetch trigger, training, idle),
 * lowest engine index first within a class
 */

`timescale 1ns/100ps

module hwpf_snoop_dispatch #(
  parameter int unsigned NUM_ENGINES = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         snoop_valid_i,
  input  hwpf_pkg::hwpf_nline_t        snoop_nline_i,
  input  logic       [NUM_ENGINES-1:0] match_pfetch_i,
  input  logic       [NUM_ENGINES-1:0] match_train_i,
  input  logic       [NUM_ENGINES-1:0] match_idle_i,
  output logic                         snoop_valid_o,
  output hwpf_pkg::hwpf_nline_t        snoop_nline_o,
  output logic       [NUM_ENGINES-1:0] chosen_o
);

  logic [NUM_ENGINES-1:0] prio;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      snoop_valid_o <= 1'b0;
    end else begin
      snoop_valid_o <= snoop_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    snoop_nline_o <= snoop_nline_i;
  end

  // Strongest class present among all engines wins
  assign prio = (|match_pfetch_i) ? match_pfetch_i :
                (|match_train_i)  ? match_train_i  : match_idle_i;

  // Keep only the lowest set bit, nothing without a snoop
  assign chosen_o = snoop_valid_o ? (prio & (~prio + 1'b1)) : '0;

endmodule

//--- src/hwpf_walker.sv
/*
 * Per-engine stride walker: Idle/Train/Prefetch FSM with snoop-driven
 * timeout, match flags toward the dispatcher and the prefetch window
 * toward the request generator
 */

`timescale 1ns/100ps

module hwpf_walker #(
  parameter int unsigned STRIDE_WIDTH      = 12,
  parameter int unsigned MAX_LOG2_BURST    = 3,
  parameter int unsigned TIMER_WIDTH       = 12,
  parameter int unsigned TIMEOUT_PER_FETCH = 6
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  match_valid_i,
  input  hwpf_pkg::hwpf_nline_t match_nline_i,
  input  logic                  chosen_i,
  output logic                  match_pfetch_o,
  output logic                  match_train_o,
  output logic                  match_idle_o,
  hwpf_window_if.walker         win
);
  import hwpf_pkg::*;

  localparam int unsigned LCOUNT_WIDTH = $clog2(MAX_LOG2_BURST + 1);

  hwpf_state_t                    state_q, state_d;
  // Training base in Train, base of the last issued window in Prefetch
  hwpf_nline_t                    base_q, base_d;
  hwpf_nline_t                    trig_q, trig_d;
  logic signed [STRIDE_WIDTH-1:0] stride_q, stride_d;
  logic        [LCOUNT_WIDTH-1:0] lcount_q, lcount_d;
  logic        [TIMER_WIDTH-1:0]  timer_q, timer_d;

  logic                           take;
  logic                           expired;
  logic                           update;
  logic signed [STRIDE_WIDTH-1:0] stride_new;
  hwpf_nline_t                    step;

  assign take    = match_valid_i & chosen_i;
  assign expired = (timer_q == '0);

  // Candidate stride from the training snoop
  assign stride_new = STRIDE_WIDTH'(match_nline_i - base_q);

  // Distance covered by the last window, sign-extended stride times length
  assign step = hwpf_nline_t'(stride_q) << lcount_q;

  // An expiring engine stops claiming snoops
  assign match_idle_o   = (state_q == HWPF_IDLE);
  assign match_train_o  = (state_q == HWPF_TRAIN) && !expired &&
                          hwpf_same_region(match_nline_i, base_q);
  assign match_pfetch_o = (state_q == HWPF_PREFETCH) && !expired &&
                          (match_nline_i == trig_q);

  always_comb begin
    state_d  = state_q;
    base_d   = base_q;
    trig_d   = trig_q;
    stride_d = stride_q;
    lcount_d = lcount_q;
    update   = 1'b0;

    // Timer runs down on every snoop seen
    timer_d = (match_valid_i && !expired) ? timer_q - 1'b1 : timer_q;

    case (state_q)
      HWPF_IDLE: begin
        if (take) begin
          base_d  = match_nline_i;
          timer_d = TIMER_WIDTH'(TIMEOUT_PER_FETCH);
          state_d = HWPF_TRAIN;
        end
      end

      HWPF_TRAIN: begin
        if (expired) begin
          state_d = HWPF_IDLE;
        end else if (take && (match_nline_i != base_q)) begin
          // First window starts one stride past the training snoop
          stride_d = stride_new;
          base_d   = match_nline_i + hwpf_nline_t'(stride_new);
          trig_d   = base_d;
          lcount_d = LCOUNT_WIDTH'(1);
          timer_d  = TIMER_WIDTH'(2 * TIMEOUT_PER_FETCH);
          update   = 1'b1;
          state_d  = HWPF_PREFETCH;
        end
        // Zero stride is swallowed here
      end

      HWPF_PREFETCH: begin
        if (expired) begin
          state_d = HWPF_IDLE;
        end else if (take) begin
          base_d = base_q + step;
          trig_d = base_d;
          if (lcount_q != LCOUNT_WIDTH'(MAX_LOG2_BURST)) begin
            lcount_d = lcount_q + 1'b1;
          end
          timer_d = TIMER_WIDTH'(TIMEOUT_PER_FETCH) << lcount_d;
          update  = 1'b1;
        end
      end

      default: begin
        state_d = HWPF_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= HWPF_IDLE;
      timer_q <= '0;
    end else begin
      state_q <= state_d;
      timer_q <= timer_d;
    end
  end

  always_ff @(posedge clk_i) begin
    base_q   <= base_d;
    trig_q   <= trig_d;
    stride_q <= stride_d;
    lcount_q <= lcount_d;
  end

  // Generator loads the new window at the same edge the FSM moves
  assign win.base   = base_d;
  assign win.stride = stride_d;
  assign win.lcount = lcount_d;
  assign win.update = update;
  assign win.ena    = (state_q == HWPF_PREFETCH);

endmodule

//--- src/hwpf_req_gen.sv
/*
 * Per-engine request generator: turns the prefetch window into a
 * stream of line addresses, one per accepted valid/ready transfer
 */

`timescale 1ns/100ps

module hwpf_req_gen #(
  parameter int unsigned STRIDE_WIDTH = 12,
  parameter int unsigned TIMER_WIDTH  = 12
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  req_ready_i,
  output logic                  req_valid_o,
  output hwpf_pkg::hwpf_nline_t req_nline_o,
  hwpf_window_if.gen            win
);
  import hwpf_pkg::*;

  logic        [TIMER_WIDTH-1:0]  cnt_q;
  logic        [TIMER_WIDTH-1:0]  burst_len;
  hwpf_nline_t                    line_q;
  logic signed [STRIDE_WIDTH-1:0] stride;
  logic                           held_q;
  logic                           xfer;
  logic                           extend;

  assign stride    = win.stride;
  assign burst_len = TIMER_WIDTH'(1) << win.lcount;

  // A stalled request stays up even if the walker drops out of Prefetch
  assign req_valid_o = (cnt_q != '0) && (win.ena || held_q);
  assign req_nline_o = line_q;
  assign xfer        = req_valid_o & req_ready_i;

  // Next window begins exactly where the running one ends,
  // so an unfinished burst is lengthened instead of restarted
  assign extend = win.ena && (cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q  <= '0;
      held_q <= 1'b0;
    end else begin
      held_q <= req_valid_o & ~req_ready_i;
      if (win.update) begin
        if (extend) begin
          cnt_q <= cnt_q - TIMER_WIDTH'(xfer) + burst_len;
        end else begin
          cnt_q <= burst_len;
        end
      end else if (xfer) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (win.update && !extend) begin
      line_q <= win.base;
    end else if (xfer) begin
      line_q <= line_q + hwpf_nline_t'(stride);
    end
  end

endmodule

//--- src/hwpf_arb.sv
/*
 * Round-robin arbiter from the engines to the single cache request
 * port, grant held while the port stalls
 */

`timescale 1ns/100ps

module hwpf_arb #(
  parameter  int unsigned NUM_ENGINES  = 2,
  localparam int unsigned ENGINE_WIDTH = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1
) (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic                   [NUM_ENGINES-1:0] valid_i,
  input  hwpf_pkg::hwpf_nline_t  [NUM_ENGINES-1:0] nline_i,
  output logic                   [NUM_ENGINES-1:0] ready_o,
  output logic                                     req_valid_o,
  output hwpf_pkg::hwpf_nline_t                    req_nline_o,
  output logic                  [ENGINE_WIDTH-1:0] req_engine_o,
  input  logic                                     req_ready_i
);

  logic [ENGINE_WIDTH-1:0] ptr_q;
  logic [ENGINE_WIDTH-1:0] grant_q;
  logic [ENGINE_WIDTH-1:0] grant;
  logic                    lock_q;
  logic                    xfer;

  // Search starts right after the engine served last
  always_comb begin
    int unsigned idx;
    logic        found;

    grant = grant_q;
    found = lock_q;
    for (int unsigned i = 1; i <= NUM_ENGINES; i++) begin
      idx = (int'(ptr_q) + i) % NUM_ENGINES;
      if (!found && valid_i[idx]) begin
        found = 1'b1;
        grant = ENGINE_WIDTH'(idx);
      end
    end
  end

  assign req_valid_o  = valid_i[grant];
  assign req_nline_o  = nline_i[grant];
  assign req_engine_o = grant;
  assign xfer         = req_valid_o & req_ready_i;

  always_comb begin
    ready_o        = '0;
    ready_o[grant] = xfer;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q   <= ENGINE_WIDTH'(NUM_ENGINES - 1);
      grant_q <= '0;
      lock_q  <= 1'b0;
    end else begin
      grant_q <= grant;
      // Stalled offer keeps its grant
      lock_q  <= req_valid_o & ~req_ready_i;
      if (xfer) begin
        ptr_q <= grant;
      end
    end
  end

endmodule

//--- src/hwpf_snoop_top.sv
/*
 * Snooping stride prefetcher top level: dispatcher, per-engine walker
 * and request generator pairs, and the request arbiter
 */

`timescale 1ns/100ps

module hwpf_snoop_top #(
  parameter  int unsigned NUM_ENGINES       = 2,
  parameter  int unsigned STRIDE_WIDTH      = 12,
  parameter  int unsigned MAX_LOG2_BURST    = 3,
  parameter  int unsigned TIMER_WIDTH       = 12,
  parameter  int unsigned TIMEOUT_PER_FETCH = 6,
  localparam int unsigned ENGINE_WIDTH      = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          snoop_valid_i,
  input  hwpf_pkg::hwpf_nline_t         snoop_nline_i,
  output logic                          req_valid_o,
  output hwpf_pkg::hwpf_nline_t         req_nline_o,
  output logic       [ENGINE_WIDTH-1:0] req_engine_o,
  input  logic                          req_ready_i
);
  import hwpf_pkg::*;

  logic                             snoop_valid;
  hwpf_nline_t                      snoop_nline;
  logic           [NUM_ENGINES-1:0] match_pfetch;
  logic           [NUM_ENGINES-1:0] match_train;
  logic           [NUM_ENGINES-1:0] match_idle;
  logic           [NUM_ENGINES-1:0] chosen;
  logic           [NUM_ENGINES-1:0] eng_valid;
  logic           [NUM_ENGINES-1:0] eng_ready;
  hwpf_nline_t    [NUM_ENGINES-1:0] eng_nline;

  hwpf_snoop_dispatch #(
    .NUM_ENGINES (NUM_ENGINES)
  ) u_dispatch (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .snoop_valid_i  (snoop_valid_i),
    .snoop_nline_i  (snoop_nline_i),
    .match_pfetch_i (match_pfetch),
    .match_train_i  (match_train),
    .match_idle_i   (match_idle),
    .snoop_valid_o  (snoop_valid),
    .snoop_nline_o  (snoop_nline),
    .chosen_o       (chosen)
  );

  for (genvar e = 0; e < NUM_ENGINES; e++) begin : gen_engine
    hwpf_window_if #(
      .STRIDE_WIDTH   (STRIDE_WIDTH),
      .MAX_LOG2_BURST (MAX_LOG2_BURST)
    ) win_if ();

    hwpf_walker #(
      .STRIDE_WIDTH      (STRIDE_WIDTH),
      .MAX_LOG2_BURST    (MAX_LOG2_BURST),
      .TIMER_WIDTH       (TIMER_WIDTH),
      .TIMEOUT_PER_FETCH (TIMEOUT_PER_FETCH)
    ) u_walker (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .match_valid_i  (snoop_valid),
      .match_nline_i  (snoop_nline),
      .chosen_i       (chosen[e]),
      .match_pfetch_o (match_pfetch[e]),
      .match_train_o  (match_train[e]),
      .match_idle_o   (match_idle[e]),
      .win            (win_if.walker)
    );

    hwpf_req_gen #(
      .STRIDE_WIDTH (STRIDE_WIDTH),
      .TIMER_WIDTH  (TIMER_WIDTH)
    ) u_req_gen (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_ready_i (eng_ready[e]),
      .req_valid_o (eng_valid[e]),
      .req_nline_o (eng_nline[e]),
      .win         (win_if.gen)
    );
  end

  hwpf_arb #(
    .NUM_ENGINES (NUM_ENGINES)
  ) u_arb (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .valid_i      (eng_valid),
    .nline_i      (eng_nline),
    .ready_o      (eng_ready),
    .req_valid_o  (req_valid_o),
    .req_nline_o  (req_nline_o),
    .req_engine_o (req_engine_o),
    .req_ready_i  (req_ready_i)
  );

endmodule

//--- tests/hwpf_snoop_chk.sv
/*
 * Concurrent assertions on the request handshake and the dispatcher
 * choice, bound into the prefetcher top level
 */

`timescale 1ns/100ps

module hwpf_snoop_chk #(
  parameter int unsigned NUM_ENGINES  = 2,
  parameter int unsigned ENGINE_WIDTH = 1
) (
  input logic                          clk_i,
  input logic                          rst_i,
  input logic                          req_valid_i,
  input logic                          req_ready_i,
  input hwpf_pkg::hwpf_nline_t         req_nline_i,
  input logic       [ENGINE_WIDTH-1:0] req_engine_i,
  input logic        [NUM_ENGINES-1:0] chosen_i
);

  // Failed assertions, read back by the testbench
  int unsigned fail_cnt = 0;

  // A stalled request keeps its line and engine until accepted
  a_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (req_valid_i && !req_ready_i) |=>
      (req_valid_i && $stable(req_nline_i) && $stable(req_engine_i)))
  else begin
    $error("stalled request dropped or changed before it was accepted");
    fail_cnt++;
  end

  a_chosen_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(chosen_i))
  else begin
    $error("dispatcher chose more than one engine");
    fail_cnt++;
  end

  // First cycle out of reset
  a_quiet_after_reset: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !req_valid_i)
  else begin
    $error("request valid right after reset");
    fail_cnt++;
  end

endmodule

bind hwpf_snoop_top hwpf_snoop_chk #(
  .NUM_ENGINES  (NUM_ENGINES),
  .ENGINE_WIDTH (ENGINE_WIDTH)
) u_chk (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .req_valid_i  (req_valid_o),
  .req_ready_i  (req_ready_i),
  .req_nline_i  (req_nline_o),
  .req_engine_i (req_engine_o),
  .chosen_i     (chosen)
);

//--- tests/hwpf_snoop_tb.sv
/*
 * Testbench for the snooping stride prefetcher: clock and reset,
 * stream model of the engines, request collector and directed tests
 */

`timescale 1ns/100ps

module hwpf_snoop_tb;
  import hwpf_pkg::*;

  localparam int unsigned MAX_BURST    = 8;
  localparam int unsigned TIMEOUT      = 6;
  localparam int unsigned WAIT_LIMIT   = 400;
  localparam int unsigned QUIET_CYCLES = 20;

  logic        clk_i;
  logic        rst_i;
  logic        snoop_valid_i;
  hwpf_nline_t snoop_nline_i;
  logic        req_ready_i;
  logic        req_valid_o;
  hwpf_nline_t req_nline_o;
  logic        req_engine_o;

  // Transfers seen on the request port, line and engine id
  hwpf_nline_t got_line[$];
  int          got_eng[$];

  bit          stall_mode;
  bit [255:0]  ready_pat;
  int unsigned cyc_cnt;
  int unsigned checks;
  int unsigned errors;
  int unsigned tests;

  hwpf_snoop_top DUT (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .snoop_valid_i (snoop_valid_i),
    .snoop_nline_i (snoop_nline_i),
    .req_valid_o   (req_valid_o),
    .req_nline_o   (req_nline_o),
    .req_engine_o  (req_engine_o),
    .req_ready_i   (req_ready_i)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (!rst_i && req_valid_o === 1'b1 && req_ready_i) begin
      got_line.push_back(req_nline_o);
      got_eng.push_back(int'(req_engine_o));
    end
  end

  // Ready follows a fixed random pattern while stalls are on
  always @(posedge clk_i) begin
    #2;
    req_ready_i = stall_mode ? ready_pat[cyc_cnt[7:0]] : 1'b1;
    cyc_cnt = cyc_cnt + 1;
  end

  task automatic apply_reset();
    rst_i = 1'b1;
    snoop_valid_i = 1'b0;
    repeat (3) begin
      @(posedge clk_i);
      #2;
    end
    rst_i = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic send_snoop(input hwpf_nline_t line);
    snoop_valid_i = 1'b1;
    snoop_nline_i = line;
    @(posedge clk_i);
    #2;
    snoop_valid_i = 1'b0;
  endtask

  task automatic start_test(input bit stalled);
    stall_mode = 1'b0;
    apply_reset();
    got_line.delete();
    got_eng.delete();
    stall_mode = stalled;
  endtask

  task automatic finish_test(input string name, input int unsigned err0);
    tests++;
    $display("%s: %0d errors", name, errors - err0);
  endtask

  task automatic expect_true(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      $display("MISMATCH at %0t: %s", $time, msg);
      errors++;
    end
  endtask

  // Region-aligned random base with headroom above it
  function automatic hwpf_nline_t rand_base();
    return hwpf_nline_t'(($urandom % 32'h10_0000) << 4);
  endfunction

  // First window holds two lines one stride past the training snoop,
  // each trigger (base of the last window) adds a window twice as long
  task automatic model_stream(input hwpf_nline_t a, input int s, input int nwin,
                              ref hwpf_nline_t lines[$], ref hwpf_nline_t trigs[$]);
    hwpf_nline_t line;
    int          len;
    line = a + hwpf_nline_t'(2 * s);
    len  = 2;
    for (int w = 0; w < nwin; w++) begin
      trigs.push_back(line);
      for (int j = 0; j < len; j++) begin
        lines.push_back(line);
        line = line + hwpf_nline_t'(s);
      end
      len = (len < MAX_BURST) ? 2 * len : MAX_BURST;
    end
  endtask

  task automatic wait_requests(input int n, input string name);
    int cyc;
    cyc = 0;
    while (got_line.size() < n && cyc < WAIT_LIMIT) begin
      @(posedge clk_i);
      #2;
      cyc++;
    end
    if (got_line.size() < n) begin
      $display("Timeout in %s: only %0d of %0d requests arrived", name, got_line.size(), n);
      errors++;
    end
    // Surplus requests would land in the queue here
    idle_cycles(QUIET_CYCLES);
    expect_true(got_line.size() <= n, $sformatf("%s: %0d requests, only %0d expected",
                name, got_line.size(), n));
  endtask

  task automatic compare_engine(input int eng, ref hwpf_nline_t exp[$]);
    int k;
    k = 0;
    foreach (got_line[i]) begin
      if (got_eng[i] == eng) begin
        if (k < exp.size()) begin
          expect_true(got_line[i] == exp[k], $sformatf("engine %0d line %0d: got %h, expected %h",
                      eng, k, got_line[i], exp[k]));
        end
        k++;
      end
    end
    expect_true(k == exp.size(), $sformatf("engine %0d issued %0d lines, expected %0d",
                eng, k, exp.size()));
  endtask

  task automatic idle_after_reset();
    int unsigned err0;
    err0 = errors;
    start_test(1'b0);
    idle_cycles(20);
    expect_true(got_line.size() == 0, "request issued without any snoop");
    send_snoop(rand_base());
    idle_cycles(20);
    expect_true(got_line.size() == 0, "request issued after a single snoop");
    finish_test("idle_after_reset", err0);
  endtask

  task automatic stride_learning();
    int unsigned err0;
    hwpf_nline_t a;
    int          s;
    hwpf_nline_t lines[$];
    hwpf_nline_t trigs[$];
    err0 = errors;
    start_test(1'b0);
    a = rand_base();
    s = 1 + ($urandom % 7);
    model_stream(a, s, 1, lines, trigs);
    send_snoop(a);
    send_snoop(a + hwpf_nline_t'(s));
    wait_requests(lines.size(), "stride_learning");
    compare_engine(0, lines);
    // Same line twice gives a zero stride
    start_test(1'b0);
    a = rand_base();
    send_snoop(a);
    send_snoop(a);
    idle_cycles(QUIET_CYCLES);
    expect_true(got_line.size() == 0, "zero stride produced requests");
    finish_test("stride_learning", err0);
  endtask

  task automatic burst_doubling();
    int unsigned err0;
    hwpf_nline_t a;
    int          s;
    hwpf_nline_t lines[$];
    hwpf_nline_t trigs[$];
    err0 = errors;
    start_test(1'b0);
    a = rand_base();
    s = 1 + ($urandom % 7);
    // Windows of 2, 4, 8, 8 and 8 lines
    model_stream(a, s, 5, lines, trigs);
    send_snoop(a);
    send_snoop(a + hwpf_nline_t'(s));
    for (int w = 0; w < 4; w++) begin
      idle_cycles(3);
      send_snoop(trigs[w]);
    end
    wait_requests(lines.size(), "burst_doubling");
    compare_engine(0, lines);
    finish_test("burst_doubling", err0);
  endtask

  task automatic two_streams(input bit stalled, input string name);
    int unsigned err0;
    hwpf_nline_t a;
    hwpf_nline_t c;
    int          s;
    int          t;
    hwpf_nline_t lines_a[$];
    hwpf_nline_t trigs_a[$];
    hwpf_nline_t lines_c[$];
    hwpf_nline_t trigs_c[$];
    err0 = errors;
    start_test(stalled);
    a = rand_base();
    c = a + hwpf_nline_t'(26'h400);
    s = 1 + ($urandom % 7);
    t = 1 + ($urandom % 7);
    model_stream(a, s, 4, lines_a, trigs_a);
    model_stream(c, t, 4, lines_c, trigs_c);
    send_snoop(a);
    send_snoop(c);
    send_snoop(a + hwpf_nline_t'(s));
    send_snoop(c + hwpf_nline_t'(t));
    for (int w = 0; w < 3; w++) begin
      idle_cycles(2);
      send_snoop(trigs_a[w]);
      send_snoop(trigs_c[w]);
    end
    wait_requests(lines_a.size() + lines_c.size(), name);
    compare_engine(0, lines_a);
    compare_engine(1, lines_c);
    finish_test(name, err0);
  endtask

  task automatic timeout_retrain();
    int unsigned err0;
    hwpf_nline_t a;
    hwpf_nline_t u;
    hwpf_nline_t t0;
    hwpf_nline_t lines[$];
    hwpf_nline_t trigs[$];
    err0 = errors;
    start_test(1'b0);
    a = rand_base();
    u = a + hwpf_nline_t'(26'h1_0000);
    model_stream(a, 1, 1, lines, trigs);
    t0 = trigs[0];
    // Retraining from the old trigger with stride 2
    model_stream(t0, 2, 1, lines, trigs);
    send_snoop(a);
    send_snoop(a + hwpf_nline_t'(1));
    // One snoop per region uses up the first-window budget
    for (int i = 0; i < 2 * TIMEOUT; i++) begin
      send_snoop(u + hwpf_nline_t'(32 * i));
    end
    idle_cycles(4);
    send_snoop(t0);
    send_snoop(t0 + hwpf_nline_t'(2));
    wait_requests(lines.size(), "timeout_retrain");
    compare_engine(0, lines);
    finish_test("timeout_retrain", err0);
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_i         = 1'b1;
    snoop_valid_i = 1'b0;
    snoop_nline_i = '0;
    req_ready_i   = 1'b1;
    stall_mode    = 1'b0;
    cyc_cnt       = 0;
    checks        = 0;
    errors        = 0;
    tests         = 0;
    void'($urandom(32'hef5a_f631));
    // Ready low about one cycle in three
    for (int i = 0; i < 256; i++) begin
      ready_pat[i] = (($urandom % 3) != 0);
    end

    idle_after_reset();
    stride_learning();
    burst_doubling();
    two_streams(1'b0, "two_streams");
    two_streams(1'b1, "back_pressure");
    timeout_retrain();

    errors = errors + DUT.u_chk.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
src/hwpf_pkg.sv
src/hwpf_window_if.sv
src/hwpf_snoop_dispatch.sv
src/hwpf_walker.sv
src/hwpf_req_gen.sv
src/hwpf_arb.sv
src/hwpf_snoop_top.sv
tests/hwpf_snoop_chk.sv
tests/hwpf_snoop_tb.sv
